//--- Bender.yml
package:
  name: alu_system

sources:
  - include_dirs:
      - src
    files:
      - src/aluPkg.sv
      - src/funcRegister.sv
      - src/generalRegs.sv
      - src/addressRegs.sv
      - src/arithLogicUnit.sv
      - src/scratchRam.sv
      - src/datapath.sv
      - src/apbControl.sv
      - src/aluSystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/aluSystemModel.sv
      - testbench/aluSystemTb.sv

//--- sim.f
+incdir+src
src/aluPkg.sv
src/funcRegister.sv
src/generalRegs.sv
src/addressRegs.sv
src/arithLogicUnit.sv
src/scratchRam.sv
src/datapath.sv
src/apbControl.sv
src/aluSystem.sv
testbench/aluSystemModel.sv
testbench/aluSystemTb.sv

//--- src/addressRegs.sv
/* Address register file
   PC, AR and SP with two read ports; port D addresses the RAM */
module addressRegs (
    input  logic            clock,
    input  logic            rstN,
    input  logic            step,
    input  logic [2:0]      enable,
    input  aluPkg::regFuncT func,
    input  aluPkg::dataT    d,
    input  logic [1:0]      outCSel,
    input  logic [1:0]      outDSel,
    output aluPkg::dataT    outC,
    output aluPkg::dataT    outD
);
    import aluPkg::*;

    dataT pc;
    dataT ar;
    dataT sp;

    function automatic dataT pick(input logic [1:0] code, input dataT pcQ, input dataT arQ,
                                  input dataT spQ);
        case (code)
            2'd2:    return arQ;
            2'd3:    return spQ;
            default: return pcQ;   // Codes 0 and 1
        endcase
    endfunction

    funcRegister #(.payloadT(dataT)) pc_inst (
        .clock(clock), .rstN(rstN), .enable(step && enable[2]), .func(func), .d(d), .q(pc)
    );
    funcRegister #(.payloadT(dataT)) ar_inst (
        .clock(clock), .rstN(rstN), .enable(step && enable[1]), .func(func), .d(d), .q(ar)
    );
    funcRegister #(.payloadT(dataT)) sp_inst (
        .clock(clock), .rstN(rstN), .enable(step && enable[0]), .func(func), .d(d), .q(sp)
    );

    assign outC = pick(outCSel, pc, ar, sp);
    assign outD = pick(outDSel, pc, ar, sp);

endmodule

//--- src/aluDefs.svh
/* ALU system constants
   Widths, APB register offsets and the register and ALU function codes */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define DATA_W          8
`define IR_W            16
`define RAM_DEPTH       256
`define APB_ADDR_W      12
`define APB_DATA_W      32

`define OFS_RAM_BASE    12'h000   // 256 bytes, one per APB word
`define OFS_SELECT      12'h100
`define OFS_ACTION      12'h104
`define OFS_ALU_STATUS  12'h108
`define OFS_IR          12'h10C
`define OFS_REG_OUT     12'h110

`define REG_DEC         2'd0
`define REG_INC         2'd1
`define REG_LOAD        2'd2
`define REG_CLEAR       2'd3

`define ALU_PASS_A      4'd0
`define ALU_PASS_B      4'd1
`define ALU_NOT_A       4'd2
`define ALU_NOT_B       4'd3
`define ALU_ADD         4'd4
`define ALU_ADDC        4'd5
`define ALU_SUB         4'd6
`define ALU_AND         4'd7
`define ALU_OR          4'd8
`define ALU_XOR         4'd9
`define ALU_LSL         4'd10
`define ALU_LSR         4'd11
`define ALU_ASL         4'd12
`define ALU_ASR         4'd13
`define ALU_ROL         4'd14
`define ALU_ROR         4'd15

`endif

//--- src/aluPkg.sv
/* ALU system types
   Function codes, flags and the control words the APB block hands to the datapath */
`include "aluDefs.svh"

package aluPkg;

    typedef logic [`DATA_W-1:0] dataT;
    typedef logic [`IR_W-1:0]   irT;

    typedef enum logic [1:0] {
        regDec   = `REG_DEC,
        regInc   = `REG_INC,
        regLoad  = `REG_LOAD,
        regClear = `REG_CLEAR
    } regFuncT;

    typedef enum logic [3:0] {
        aluPassA = `ALU_PASS_A,
        aluPassB = `ALU_PASS_B,
        aluNotA  = `ALU_NOT_A,
        aluNotB  = `ALU_NOT_B,
        aluAdd   = `ALU_ADD,
        aluAddC  = `ALU_ADDC,
        aluSub   = `ALU_SUB,
        aluAnd   = `ALU_AND,
        aluOr    = `ALU_OR,
        aluXor   = `ALU_XOR,
        aluLsl   = `ALU_LSL,
        aluLsr   = `ALU_LSR,
        aluAsl   = `ALU_ASL,
        aluAsr   = `ALU_ASR,
        aluRol   = `ALU_ROL,  // Through carry
        aluRor   = `ALU_ROR
    } aluFuncT;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flagsT;

    // Multiplexer and read-port selects, held as levels
    typedef struct packed {
        logic [1:0] rfOutASel;
        logic [1:0] rfOutBSel;
        logic [1:0] arfOutCSel;   // 0 and 1 pick PC
        logic [1:0] arfOutDSel;
        logic [1:0] muxASel;      // IR low, RAM, ARF C, ALU
        logic [1:0] muxBSel;      // ARF C, IR low, RAM, ALU
        logic       muxCSel;      // ARF C, RF A
    } datapathSelT;

    typedef struct packed {
        regFuncT    rfFunc;
        logic [3:0] rfEnable;     // MSB enables register 0
        aluFuncT    aluFunc;
        logic       aluUpdate;
        regFuncT    arfFunc;
        logic [2:0] arfEnable;    // PC, AR, SP from MSB
        logic       irEnable;
        logic       irLoadHigh;
        regFuncT    irFunc;
        logic       memWrite;
    } datapathActT;

    // Output A ends up in the low byte
    typedef struct packed {
        dataT outD;
        dataT outC;
        dataT outB;
        dataT outA;
    } regOutT;

endpackage

//--- src/aluSystem.sv
/* ALU system top
   The APB control block steering the datapath */
`include "aluDefs.svh"

module aluSystem (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import aluPkg::*;

    datapathSelT sel;
    datapathActT act;
    logic        step;
    dataT        hostAddr;
    dataT        hostWData;
    logic        hostWrite;
    dataT        hostRData;
    dataT        aluResult;
    flagsT       flags;
    irT          ir;
    regOutT      regOut;

    apbControl apbControl_inst (.*);

    datapath datapath_inst (.*);

endmodule

//--- src/apbControl.sv
/* APB control block
   Holds the select and action words, fires one step per action write,
   and maps the RAM window and the status registers */
`include "aluDefs.svh"

module apbControl (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output aluPkg::datapathSelT    sel,
    output aluPkg::datapathActT    act,
    output logic                   step,
    output aluPkg::dataT           hostAddr,
    output aluPkg::dataT           hostWData,
    output logic                   hostWrite,
    input  aluPkg::dataT           hostRData,
    input  aluPkg::dataT           aluResult,
    input  aluPkg::flagsT          flags,
    input  aluPkg::irT             ir,
    input  aluPkg::regOutT         regOut
);
    import aluPkg::*;

    logic access, wrAccess;
    logic ramHit, selHit, actHit, aluHit, irHit, regHit, statusHit;

    assign access   = psel && penable;
    assign wrAccess = access && pwrite;

    assign ramHit    = (paddr >= `OFS_RAM_BASE) && (paddr < `OFS_RAM_BASE + `RAM_DEPTH);
    assign selHit    = (paddr == `OFS_SELECT);
    assign actHit    = (paddr == `OFS_ACTION);
    assign aluHit    = (paddr == `OFS_ALU_STATUS);
    assign irHit     = (paddr == `OFS_IR);
    assign regHit    = (paddr == `OFS_REG_OUT);
    assign statusHit = aluHit || irHit || regHit;

    assign pready  = 1'b1;   // No wait states
    assign pslverr = access && (!(ramHit || selHit || actHit || statusHit)
                                || (pwrite && statusHit));

    assign hostAddr  = paddr[$bits(dataT)-1:0];
    assign hostWData = pwdata[$bits(dataT)-1:0];
    assign hostWrite = wrAccess && ramHit;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            sel  <= '0;
            act  <= '0;
            step <= 1'b0;
        end else begin
            step <= wrAccess && actHit;   // Datapath moves one cycle after the transfer
            if (wrAccess && selHit) begin
                sel <= pwdata[$bits(datapathSelT)-1:0];
            end
            if (wrAccess && actHit) begin
                act <= pwdata[$bits(datapathActT)-1:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (ramHit) begin
            prdata[$bits(dataT)-1:0] = hostRData;
        end else if (selHit) begin
            prdata[$bits(datapathSelT)-1:0] = sel;
        end else if (actHit) begin
            prdata[$bits(datapathActT)-1:0] = act;
        end else if (aluHit) begin
            prdata[$bits(flagsT)+$bits(dataT)-1:0] = {flags, aluResult};
        end else if (irHit) begin
            prdata[$bits(irT)-1:0] = ir;
        end else if (regHit) begin
            prdata = regOut;
        end
    end

endmodule

//--- src/arithLogicUnit.sv
/* Arithmetic logic unit
   Sixteen combinational functions and a flag register loaded on a step */
module arithLogicUnit (
    input  logic            clock,
    input  logic            rstN,
    input  logic            step,
    input  logic            update,
    input  aluPkg::aluFuncT func,
    input  aluPkg::dataT    a,
    input  aluPkg::dataT    b,
    output aluPkg::dataT    result,
    output aluPkg::flagsT   flags
);
    import aluPkg::*;

    logic [$bits(dataT):0] sum;   // Carry or borrow in the top bit
    flagsT                 nextFlags;

    always_comb begin
        nextFlags = flags;
        sum       = '0;
        result    = '0;
        case (func)
            aluPassA: result = a;
            aluPassB: result = b;
            aluNotA:  result = ~a;
            aluNotB:  result = ~b;
            aluAdd, aluAddC: begin
                sum = {1'b0, a} + {1'b0, b};
                if (func == aluAddC) begin
                    sum = sum + flags.carry;
                end
                result             = sum[7:0];
                nextFlags.carry    = sum[8];
                nextFlags.overflow = (a[7] == b[7]) && (result[7] != a[7]);
            end
            aluSub: begin
                sum                = {1'b0, a} - {1'b0, b};
                result             = sum[7:0];
                nextFlags.carry    = sum[8];   // Borrow
                nextFlags.overflow = (a[7] != b[7]) && (result[7] != a[7]);
            end
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluLsl: begin
                result          = {a[6:0], 1'b0};
                nextFlags.carry = a[7];
            end
            aluLsr: begin
                result          = {1'b0, a[7:1]};
                nextFlags.carry = a[0];
            end
            aluAsl: begin
                result             = {a[6:0], 1'b0};
                nextFlags.carry    = a[7];
                nextFlags.overflow = a[7] ^ a[6];
            end
            aluAsr: begin
                result          = {a[7], a[7:1]};   // Sign kept
                nextFlags.carry = a[0];
            end
            aluRol: begin
                result             = {a[6:0], flags.carry};
                nextFlags.carry    = a[7];
                nextFlags.overflow = a[7] ^ a[6];
            end
            aluRor: begin
                result             = {flags.carry, a[7:1]};
                nextFlags.carry    = a[0];
                nextFlags.overflow = a[7] ^ flags.carry;
            end
            default: result = a;
        endcase
        nextFlags.zero     = (result == '0);
        nextFlags.negative = result[7];
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (step && update) begin
            flags <= nextFlags;
        end
    end

endmodule

//--- src/datapath.sv
/* Datapath
   Register files, IR, ALU and RAM joined by the three source multiplexers */
module datapath (
    input  logic                clock,
    input  logic                rstN,
    input  logic                step,
    input  aluPkg::datapathSelT sel,
    input  aluPkg::datapathActT act,
    input  aluPkg::dataT        hostAddr,
    input  aluPkg::dataT        hostWData,
    input  logic                hostWrite,
    output aluPkg::dataT        hostRData,
    output aluPkg::dataT        aluResult,
    output aluPkg::flagsT       flags,
    output aluPkg::irT          ir,
    output aluPkg::regOutT      regOut
);
    import aluPkg::*;

    dataT rfOutA, rfOutB, arfOutC, arfOutD;
    dataT ramData;
    dataT muxAOut, muxBOut, muxCOut;
    irT   irLoadWord;

    always_comb begin
        case (sel.muxASel)
            2'd0:    muxAOut = ir[7:0];
            2'd1:    muxAOut = ramData;
            2'd2:    muxAOut = arfOutC;
            default: muxAOut = aluResult;
        endcase
        case (sel.muxBSel)
            2'd0:    muxBOut = arfOutC;
            2'd1:    muxBOut = ir[7:0];
            2'd2:    muxBOut = ramData;
            default: muxBOut = aluResult;
        endcase
    end

    assign muxCOut = sel.muxCSel ? rfOutA : arfOutC;

    // RAM byte goes into one half and the other half is kept
    assign irLoadWord = act.irLoadHigh ? {ramData, ir[7:0]} : {ir[15:8], ramData};

    generalRegs generalRegs_inst (
        .clock(clock), .rstN(rstN), .step(step), .enable(act.rfEnable), .func(act.rfFunc),
        .d(muxAOut), .outASel(sel.rfOutASel), .outBSel(sel.rfOutBSel),
        .outA(rfOutA), .outB(rfOutB)
    );

    addressRegs addressRegs_inst (
        .clock(clock), .rstN(rstN), .step(step), .enable(act.arfEnable), .func(act.arfFunc),
        .d(muxBOut), .outCSel(sel.arfOutCSel), .outDSel(sel.arfOutDSel),
        .outC(arfOutC), .outD(arfOutD)
    );

    funcRegister #(.payloadT(irT)) irReg_inst (
        .clock(clock), .rstN(rstN), .enable(step && act.irEnable), .func(act.irFunc),
        .d(irLoadWord), .q(ir)
    );

    arithLogicUnit arithLogicUnit_inst (
        .clock(clock), .rstN(rstN), .step(step), .update(act.aluUpdate), .func(act.aluFunc),
        .a(muxCOut), .b(rfOutB), .result(aluResult), .flags(flags)
    );

    scratchRam scratchRam_inst (
        .clock(clock), .addr(arfOutD), .wData(aluResult), .write(step && act.memWrite),
        .rData(ramData), .hostAddr(hostAddr), .hostWData(hostWData), .hostWrite(hostWrite),
        .hostRData(hostRData)
    );

    assign regOut = '{outA: rfOutA, outB: rfOutB, outC: arfOutC, outD: arfOutD};

endmodule

//--- src/funcRegister.sv
/* Function register
   Decrements, increments, loads or clears its payload when enabled */
module funcRegister #(
    parameter type payloadT = aluPkg::dataT
) (
    input  logic            clock,
    input  logic            rstN,
    input  logic            enable,
    input  aluPkg::regFuncT func,
    input  payloadT         d,
    output payloadT         q
);
    import aluPkg::*;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (enable) begin
            case (func)
                regDec:   q <= q - 1'b1;
                regInc:   q <= q + 1'b1;
                regLoad:  q <= d;
                regClear: q <= '0;
                default:  q <= q;
            endcase
        end
    end

endmodule

//--- src/generalRegs.sv
/* General register file
   Four function registers sharing one input, with two read ports */
module generalRegs (
    input  logic            clock,
    input  logic            rstN,
    input  logic            step,
    input  logic [3:0]      enable,
    input  aluPkg::regFuncT func,
    input  aluPkg::dataT    d,
    input  logic [1:0]      outASel,
    input  logic [1:0]      outBSel,
    output aluPkg::dataT    outA,
    output aluPkg::dataT    outB
);
    import aluPkg::*;

    dataT regQ [4];

    // Register 0 sits on the enable MSB
    for (genvar i = 0; i < 4; i++) begin : genReg
        funcRegister #(
            .payloadT(dataT)
        ) funcRegister_inst (
            .clock (clock),
            .rstN  (rstN),
            .enable(step && enable[3 - i]),
            .func  (func),
            .d     (d),
            .q     (regQ[i])
        );
    end

    assign outA = regQ[outASel];
    assign outB = regQ[outBSel];

endmodule

//--- src/scratchRam.sv
/* Scratch RAM
   256 bytes with a datapath port and a host port, both read combinationally */
`include "aluDefs.svh"

module scratchRam (
    input  logic              clock,
    input  logic [`DATA_W-1:0] addr,
    input  logic [`DATA_W-1:0] wData,
    input  logic              write,
    output logic [`DATA_W-1:0] rData,
    input  logic [`DATA_W-1:0] hostAddr,
    input  logic [`DATA_W-1:0] hostWData,
    input  logic              hostWrite,
    output logic [`DATA_W-1:0] hostRData
);

    logic [`DATA_W-1:0] mem [`RAM_DEPTH];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= wData;
        end
        // Host write comes last so it wins on a shared address
        if (hostWrite) begin
            mem[hostAddr] <= hostWData;
        end
    end

    assign rData     = mem[addr];
    assign hostRData = mem[hostAddr];

endmodule

//--- testbench/aluSystemModel.sv
/* ALU system reference model
   Expected ALU results and flags, register updates and IR byte loads */
package aluSystemModel;
    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;

    typedef struct packed {
        dataT  result;
        flagsT flags;
    } aluOutT;

    function automatic dataT nextRegValue(input regFuncT func, input dataT q, input dataT d);
        case (func)
            regDec:  return q - 8'd1;
            regInc:  return q + 8'd1;
            regLoad: return d;
            default: return '0;
        endcase
    endfunction

    // One RAM byte lands in the chosen half
    function automatic irT loadIrByte(input irT ir, input dataT ramByte, input logic high);
        irT word;
        word = ir;
        if (high) begin
            word[15:8] = ramByte;
        end else begin
            word[7:0] = ramByte;
        end
        return word;
    endfunction

    function automatic aluOutT computeAlu(input aluFuncT func, input dataT a, input dataT b,
                                          input flagsT old);
        aluOutT res;
        int     wide;
        int     signedSum;   // Exact signed value, checked against the 8-bit range
        logic   cin;
        res.flags = old;
        res.result = '0;
        cin = 1'b0;
        wide = 0;
        signedSum = 0;
        case (func)
            aluPassA: res.result = a;
            aluPassB: res.result = b;
            aluNotA:  res.result = ~a;
            aluNotB:  res.result = ~b;
            aluAdd, aluAddC: begin
                if (func == aluAddC) begin
                    cin = old.carry;
                end
                wide = int'(a) + int'(b) + int'(cin);
                signedSum = int'($signed(a)) + int'($signed(b)) + int'(cin);
                res.result = wide[7:0];
                res.flags.carry = (wide > 255);
                res.flags.overflow = (signedSum > 127) || (signedSum < -128);
            end
            aluSub: begin
                signedSum = int'($signed(a)) - int'($signed(b));
                res.result = a - b;
                res.flags.carry = (a < b);   // Borrow
                res.flags.overflow = (signedSum > 127) || (signedSum < -128);
            end
            aluAnd:   res.result = a & b;
            aluOr:    res.result = a | b;
            aluXor:   res.result = a ^ b;
            aluLsl: begin
                res.result = a << 1;
                res.flags.carry = a[7];
            end
            aluLsr: begin
                res.result = a >> 1;
                res.flags.carry = a[0];
            end
            aluAsl: begin
                res.result = a << 1;
                res.flags.carry = a[7];
                res.flags.overflow = a[7] ^ a[6];
            end
            aluAsr: begin
                res.result = $signed(a) >>> 1;
                res.flags.carry = a[0];
            end
            aluRol: begin
                res.result = {a[6:0], old.carry};
                res.flags.carry = a[7];
                res.flags.overflow = a[7] ^ a[6];
            end
            default: begin   // Rotate right through carry
                res.result = {old.carry, a[7:1]};
                res.flags.carry = a[0];
                res.flags.overflow = a[7] ^ old.carry;
            end
        endcase
        res.flags.zero = (res.result == 8'd0);
        res.flags.negative = res.result[7];
        return res;
    endfunction

endpackage

//--- testbench/aluSystemTb.sv
/* ALU system testbench
   Steers the datapath over APB and checks each step against the reference model */
`include "aluDefs.svh"

module aluSystemTb;
    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;
    import aluSystemModel::*;

    localparam int aluPairs         = 200;
    localparam int plannedTransfers = 300 + aluPairs * 36;   // 36 transfers per operand pair
    localparam int cycleLimit       = 4 * plannedTransfers * 3;

    logic                   clock;
    logic                   rstN;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    // Scoreboard copies of the datapath state
    dataT        ramModel [`RAM_DEPTH];
    dataT        gpr [4];
    dataT        arf [3];   // PC, AR, SP
    irT          irModel;
    flagsT       flagsModel;
    datapathSelT curSel;
    int          cycleCount;

    aluSystem aluSystem_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        failRun($sformatf("The run timed out after %0d cycles", cycleLimit));
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareFlags(input string name, input flagsT expected, input flagsT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic compareIr(input string name, input irT expected, input irT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareRegs(input string name, input regOutT expected, input regOutT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkSlaveError(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("%s: pslverr was %b where %b was expected", what, actual, expected));
        end
    endtask

    // Setup and access phase, then one idle cycle
    task automatic apbTransfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                               input logic [`APB_DATA_W-1:0] wdata,
                               output logic [`APB_DATA_W-1:0] rdata, output logic err);
        @(posedge clock);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(negedge clock);
        if (pready !== 1'b1) begin
            failRun("pready was low in the access phase");
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic writeReg(input logic [`APB_ADDR_W-1:0] addr,
                            input logic [`APB_DATA_W-1:0] data);
        logic [`APB_DATA_W-1:0] rd;
        logic                   err;
        apbTransfer(1'b1, addr, data, rd, err);
        checkSlaveError($sformatf("Write to offset %h", addr), 1'b0, err);
    endtask

    task automatic readReg(input logic [`APB_ADDR_W-1:0] addr,
                           output logic [`APB_DATA_W-1:0] data);
        logic err;
        apbTransfer(1'b0, addr, '0, data, err);
        checkSlaveError($sformatf("Read of offset %h", addr), 1'b0, err);
    endtask

    task automatic writeSel(input datapathSelT s);
        writeReg(`OFS_SELECT, 32'(s));
        curSel = s;
    endtask

    task automatic doStep(input datapathActT word);
        writeReg(`OFS_ACTION, 32'(word));
    endtask

    function automatic dataT arfPick(input logic [1:0] code);
        return (code < 2'd2) ? arf[0] : arf[code - 1];
    endfunction

    function automatic regOutT expectedRegs();
        regOutT r;
        r.outA = gpr[curSel.rfOutASel];
        r.outB = gpr[curSel.rfOutBSel];
        r.outC = arfPick(curSel.arfOutCSel);
        r.outD = arfPick(curSel.arfOutDSel);
        return r;
    endfunction

    task automatic testResetAndRam();
        logic [`APB_DATA_W-1:0] rd;
        logic                   err;
        readReg(`OFS_REG_OUT, rd);
        compareRegs("reset regOut", '0, rd);
        readReg(`OFS_IR, rd);
        compareIr("reset ir", '0, rd[15:0]);
        readReg(`OFS_ALU_STATUS, rd);
        compareData("reset alu result", '0, rd[7:0]);
        compareFlags("reset flags", '0, rd[11:8]);
        for (int i = 0; i < 32; i++) begin
            ramModel[i] = dataT'($urandom);
            writeReg(`OFS_RAM_BASE + i, ramModel[i]);
        end
        for (int i = 0; i < 32; i++) begin
            readReg(`OFS_RAM_BASE + i, rd);
            compareData($sformatf("ram byte %0d", i), ramModel[i], rd[7:0]);
        end
        apbTransfer(1'b0, 12'h200, '0, rd, err);
        checkSlaveError("Read of unmapped offset 200", 1'b1, err);
        apbTransfer(1'b1, `OFS_IR, 32'h1234, rd, err);
        checkSlaveError("Write to the read-only IR offset", 1'b1, err);
    endtask

    task automatic testRegFunctions();
        regFuncT                funcs [6] = '{regInc, regInc, regDec, regClear, regDec, regInc};
        datapathSelT            s;
        datapathActT            word;
        logic [`APB_DATA_W-1:0] rd;
        s = '0;
        s.muxBSel = 2'd2;   // PC from RAM at PC
        writeSel(s);
        word = '0;
        word.arfFunc = regLoad;
        word.arfEnable = 3'b100;
        doStep(word);
        arf[0] = nextRegValue(regLoad, arf[0], ramModel[arfPick(curSel.arfOutDSel)]);
        readReg(`OFS_REG_OUT, rd);
        compareRegs("pc load from ram", expectedRegs(), rd);
        s.muxBSel = 2'd0;   // AR and SP copy PC
        writeSel(s);
        for (int r = 1; r < 3; r++) begin
            word.arfEnable = 3'b100 >> r;
            doStep(word);
            arf[r] = nextRegValue(regLoad, arf[r], arf[0]);
        end
        for (int r = 0; r < 3; r++) begin
            s.arfOutCSel = (r == 0) ? 2'($urandom_range(0, 1)) : 2'(r + 1);
            writeSel(s);
            word.arfEnable = 3'b100 >> r;
            foreach (funcs[k]) begin
                word.arfFunc = funcs[k];
                doStep(word);
                arf[r] = nextRegValue(funcs[k], arf[r], arfPick(curSel.arfOutCSel));
                readReg(`OFS_REG_OUT, rd);
                compareRegs($sformatf("arf %0d %s", r, funcs[k].name()), expectedRegs(), rd);
            end
        end
    endtask

    task automatic testIrLoads();
        datapathSelT            s;
        datapathActT            incAr;
        datapathActT            irWord;
        logic [`APB_DATA_W-1:0] rd;
        s = curSel;
        s.arfOutDSel = 2'd2;   // RAM address from AR
        writeSel(s);
        incAr = '0;
        incAr.arfFunc = regClear;
        incAr.arfEnable = 3'b010;
        doStep(incAr);
        arf[1] = nextRegValue(regClear, arf[1], '0);
        incAr.arfFunc = regInc;
        irWord = '0;
        irWord.irEnable = 1'b1;
        irWord.irFunc = regLoad;
        for (int j = 0; j < 8; j++) begin
            irWord.irLoadHigh = j[0];
            doStep(irWord);
            irModel = loadIrByte(irModel, ramModel[arf[1]], j[0]);
            readReg(`OFS_IR, rd);
            compareIr($sformatf("ir half %0d from ram %0d", j[0], arf[1]), irModel, rd[15:0]);
            doStep(incAr);
            arf[1] = nextRegValue(regInc, arf[1], '0);
        end
        readReg(`OFS_REG_OUT, rd);
        compareRegs("registers after ir loads", expectedRegs(), rd);
    endtask

    task automatic testAluFunctions();
        datapathSelT            s;
        datapathActT            loadA;
        datapathActT            loadB;
        datapathActT            aluStep;
        logic [`APB_DATA_W-1:0] rd;
        aluOutT                 stepped;
        aluOutT                 shown;
        dataT                   ramAddr;
        string                  name;
        s = curSel;
        s.muxASel = 2'd1;   // RF input from RAM
        s.rfOutASel = 2'd0;
        s.rfOutBSel = 2'd1;
        s.muxCSel = 1'b1;
        writeSel(s);
        ramAddr = arfPick(s.arfOutDSel);
        loadA = '0;
        loadA.rfFunc = regLoad;
        loadA.rfEnable = 4'b1000;
        loadB = loadA;
        loadB.rfEnable = 4'b0100;
        aluStep = '0;
        aluStep.aluUpdate = 1'b1;
        for (int p = 0; p < aluPairs; p++) begin
            ramModel[ramAddr] = dataT'($urandom);
            writeReg(`OFS_RAM_BASE + ramAddr, ramModel[ramAddr]);
            doStep(loadA);
            gpr[0] = nextRegValue(regLoad, gpr[0], ramModel[ramAddr]);
            ramModel[ramAddr] = dataT'($urandom);
            writeReg(`OFS_RAM_BASE + ramAddr, ramModel[ramAddr]);
            doStep(loadB);
            gpr[1] = nextRegValue(regLoad, gpr[1], ramModel[ramAddr]);
            for (int f = 0; f < 16; f++) begin
                aluStep.aluFunc = aluFuncT'(f);
                doStep(aluStep);
                stepped = computeAlu(aluStep.aluFunc, gpr[0], gpr[1], flagsModel);
                flagsModel = stepped.flags;
                // Status shows the result recomputed with the carry just stored
                shown = computeAlu(aluStep.aluFunc, gpr[0], gpr[1], flagsModel);
                readReg(`OFS_ALU_STATUS, rd);
                name = $sformatf("pair %0d %s", p, aluStep.aluFunc.name());
                compareData({name, " result"}, shown.result, rd[7:0]);
                compareFlags({name, " flags"}, flagsModel, rd[11:8]);
            end
        end
    endtask

    task automatic testAluWriteback();
        datapathSelT            s;
        datapathActT            word;
        logic [`APB_DATA_W-1:0] rd;
        aluOutT                 expected;
        int                     target;
        dataT                   addr;
        for (int i = 0; i < 8; i++) begin
            target = 2 + (i % 2);
            s = curSel;
            s.muxASel = 2'd3;   // RF input from the ALU
            s.rfOutASel = 2'd0;
            writeSel(s);
            word = '0;
            word.rfFunc = regLoad;
            word.rfEnable = 4'b1000 >> target;
            word.aluFunc = aluFuncT'($urandom_range(0, 15));
            word.arfFunc = regInc;   // AR moves on at the same edge
            word.arfEnable = 3'b010;
            word.memWrite = 1'b1;
            addr = arf[1];
            expected = computeAlu(word.aluFunc, gpr[0], gpr[1], flagsModel);
            doStep(word);
            ramModel[addr] = expected.result;
            gpr[target] = expected.result;
            arf[1] = nextRegValue(regInc, arf[1], '0);
            readReg(`OFS_RAM_BASE + addr, rd);
            compareData($sformatf("ram %0d from %s", addr, word.aluFunc.name()),
                        expected.result, rd[7:0]);
            s.rfOutASel = 2'(target);
            writeSel(s);
            readReg(`OFS_REG_OUT, rd);
            compareRegs($sformatf("rf %0d from %s", target, word.aluFunc.name()),
                        expectedRegs(), rd);
        end
    endtask

    initial begin
        rstN       = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        gpr        = '{default: '0};
        arf        = '{default: '0};
        irModel    = '0;
        flagsModel = '0;
        curSel     = '0;
        void'($urandom(83844));
        repeat (10) @(posedge clock);
        #1;
        rstN = 1'b1;
        testResetAndRam();
        testRegFunctions();
        testIrLoads();
        testAluFunctions();
        testAluWriteback();
        $display("TESTS PASSED");
        $finish;
    end

endmodule
